// ==== Makefile ====
TOP = tb_fetch_top

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f verilog.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -F -q "All checks passed"

clean:
	rm -rf obj_dir

// ==== rtl/fetch_ctrl.sv ====
`timescale 1ns/1ps

module fetch_ctrl import fetch_pkg::*, mem_bus_pkg::*; (
    input  logic     clk,
    input  logic     rst_n_i,
    input  pc_t      pc_i,
    output mem_req_t mem_req_o,
    input  logic     req_ready_i,
    input  mem_rsp_t mem_rsp_i,
    output logic     rsp_ready_o,
    output logic     advance_o,
    output logic     inst_valid_o,
    output inst_t    inst_o,
    output pc_t      pc_o
);

    typedef enum logic [1:0] {
        IDLE,
        REQ,
        WAIT
    } fetch_state_e;

    fetch_state_e state_q;
    fetch_state_e state_d;

    pc_t   addr_q;        // address of the request in flight
    logic  req_hold_q;    // request seen but not yet taken
    logic  req_fire;
    logic  rsp_fire;
    logic  pc_match;
    inst_t inst_q;
    pc_t   pc_q;
    logic  inst_valid_q;

    // live pc on the first request cycle, latched copy while held
    assign mem_req_o.valid = (state_q == REQ);
    assign mem_req_o.addr  = req_hold_q ? addr_q : pc_i;
    assign rsp_ready_o     = (state_q == WAIT);

    assign req_fire = mem_req_o.valid && req_ready_i;
    assign rsp_fire = mem_rsp_i.valid && rsp_ready_o;
    assign pc_match = (addr_q == pc_i);  // a redirect since issue makes this stale

    assign advance_o = rsp_fire && pc_match;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:    state_d = REQ;
            REQ:     if (req_fire) state_d = WAIT;
            WAIT:    if (rsp_fire) state_d = REQ;  // matched or dropped
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q      <= IDLE;
            req_hold_q   <= 1'b0;
            inst_valid_q <= 1'b0;
        end else begin
            state_q      <= state_d;
            req_hold_q   <= mem_req_o.valid && !req_ready_i;
            inst_valid_q <= advance_o;  // one cycle strobe
        end
    end

    always_ff @(posedge clk) begin
        if (mem_req_o.valid && !req_hold_q) begin
            addr_q <= pc_i;  // latch on issue
        end
        if (advance_o) begin
            inst_q <= mem_rsp_i.data[31:0];
            pc_q   <= addr_q;
        end
    end

    assign inst_valid_o = inst_valid_q;
    assign inst_o       = inst_q;
    assign pc_o         = pc_q;

    req_addr_stable_a: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (mem_req_o.valid && !req_ready_i) |=> (mem_req_o.addr == $past(mem_req_o.addr))
    ) else $error("request address moved before acceptance");

    // each fetch needs a fresh request and response between strobes
    strobe_single_a: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        inst_valid_o |=> !inst_valid_o
    ) else $error("inst_valid_o high for two cycles");

endmodule

// ==== rtl/fetch_pkg.sv ====
package fetch_pkg;

    typedef logic [63:0] pc_t;    // instruction address
    typedef logic [31:0] inst_t;  // one instruction word

    localparam pc_t RESET_PC = 64'h0000_0000_8000_0000;
    localparam pc_t PC_STEP  = 64'd4;  // no compressed instructions

    // control-flow inputs for one cycle, usually from a later stage
    typedef struct packed {
        logic jal;       // jump taken
        logic branch;    // branch resolved
        logic cmp_zero;  // compare result zero, branch taken
        logic jalr;      // register jump
        logic trap;      // trap raised
        pc_t  exec_pc;   // pc of the redirecting instruction
        pc_t  imm;
        pc_t  rs1_data;
        pc_t  trap_vec;
    } redirect_t;

endpackage

// ==== rtl/fetch_top.sv ====
`timescale 1ns/1ps

module fetch_top import fetch_pkg::*, mem_bus_pkg::*; (
    input  logic      clk,
    input  logic      rst_n_i,
    input  redirect_t redirect_i,
    input  logic      stall_i,
    output logic      inst_valid_o,
    output inst_t     inst_o,
    output pc_t       pc_o
);

    pc_t      pc;
    logic     advance;
    mem_req_t mem_req;
    mem_rsp_t mem_rsp;
    logic     req_ready;
    logic     rsp_ready;

    next_pc_sel u_next_pc_sel (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .redirect_i (redirect_i),
        .stall_i    (stall_i),
        .advance_i  (advance),
        .pc_o       (pc)
    );

    fetch_ctrl u_fetch_ctrl (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .pc_i         (pc),
        .mem_req_o    (mem_req),
        .req_ready_i  (req_ready),
        .mem_rsp_i    (mem_rsp),
        .rsp_ready_o  (rsp_ready),
        .advance_o    (advance),
        .inst_valid_o (inst_valid_o),
        .inst_o       (inst_o),
        .pc_o         (pc_o)
    );

    inst_mem u_inst_mem (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .mem_req_i   (mem_req),
        .req_ready_o (req_ready),
        .mem_rsp_o   (mem_rsp),
        .rsp_ready_i (rsp_ready)
    );

endmodule

// ==== rtl/inst_mem.sv ====
`timescale 1ns/1ps

module inst_mem import fetch_pkg::*, mem_bus_pkg::*; (
    input  logic     clk,
    input  logic     rst_n_i,
    input  mem_req_t mem_req_i,
    output logic     req_ready_o,
    output mem_rsp_t mem_rsp_o,
    input  logic     rsp_ready_i
);

    logic  busy_q;   // one request in progress
    lat_t  cnt_q;    // cycles left before the response
    pc_t   addr_q;
    inst_t word;
    logic  req_fire;
    logic  rsp_fire;

    assign req_ready_o = !busy_q;
    assign req_fire    = mem_req_i.valid && req_ready_o;
    assign rsp_fire    = mem_rsp_o.valid && rsp_ready_i;

    // pattern memory, no storage needed
    assign word = addr_q[33:2] ^ MEM_PATTERN;

    // held until the handshake since addr_q does not move
    assign mem_rsp_o.valid = busy_q && (cnt_q == '0);
    assign mem_rsp_o.data  = {32'h0, word};

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
        end else if (req_fire) begin
            busy_q <= 1'b1;
            cnt_q  <= MEM_BASE_LAT + lat_t'(mem_req_i.addr[3:2]);  // 1 to 4 cycles
        end else if (rsp_fire) begin
            busy_q <= 1'b0;
        end else if (busy_q && cnt_q != '0) begin
            cnt_q <= cnt_q - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire) begin
            addr_q <= mem_req_i.addr;
        end
    end

    // a new request must never overlap a pending response
    rsp_req_overlap_a: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        mem_req_i.valid |-> !mem_rsp_o.valid
    ) else $error("request offered while a response is pending");

endmodule

// ==== rtl/mem_bus_pkg.sv ====
package mem_bus_pkg;

    import fetch_pkg::*;

    typedef logic [63:0] bus_data_t;
    typedef logic [2:0]  lat_t;  // latency count, up to 4

    // request channel, fetch side drives it
    typedef struct packed {
        logic valid;
        pc_t  addr;
    } mem_req_t;

    // response channel, memory side drives it
    typedef struct packed {
        logic      valid;
        bus_data_t data;  // instruction in the low word
    } mem_rsp_t;

    // stored word is the word index xor this pattern
    localparam inst_t MEM_PATTERN = 32'h5A5A_0000;

    // full latency adds addr[3:2] on top of this
    localparam lat_t MEM_BASE_LAT = 3'd1;

endpackage

// ==== rtl/next_pc_sel.sv ====
`timescale 1ns/1ps

module next_pc_sel import fetch_pkg::*; (
    input  logic      clk,
    input  logic      rst_n_i,
    input  redirect_t redirect_i,
    input  logic      stall_i,
    input  logic      advance_i,
    output pc_t       pc_o
);

    pc_t  pc_q;
    pc_t  pc_d;
    pc_t  jalr_sum;
    logic branch_taken;

    assign branch_taken = redirect_i.jal || (redirect_i.branch && redirect_i.cmp_zero);
    assign jalr_sum     = redirect_i.rs1_data + redirect_i.imm;

    // fixed priority, a redirect wins over stall and advance
    always_comb begin
        if (branch_taken) begin
            pc_d = redirect_i.exec_pc + redirect_i.imm;
        end else if (redirect_i.jalr) begin
            pc_d = {jalr_sum[63:1], 1'b0};  // lsb cleared for jalr
        end else if (redirect_i.trap) begin
            pc_d = redirect_i.trap_vec;
        end else if (advance_i && !stall_i) begin
            pc_d = pc_q + PC_STEP;
        end else begin
            pc_d = pc_q;  // stalled or fetch still in flight
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q <= RESET_PC;
        end else begin
            pc_q <= pc_d;
        end
    end

    assign pc_o = pc_q;

    // every source of a new pc must keep it halfword aligned
    pc_aligned_a: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        pc_q[0] == 1'b0
    ) else $error("pc not halfword aligned: %h", pc_q);

endmodule

// ==== test/tb_fetch_top.sv ====
`timescale 1ns/1ps

module tb_fetch_top import fetch_pkg::*, mem_bus_pkg::*; ();

    localparam int RESET_CYCLES   = 5;
    localparam int STIM_CYCLES    = 2000;
    localparam int TIMEOUT_CYCLES = 3000;  // stimulus plus margin
    localparam int MIN_STROBES    = 200;

    logic      clk;
    logic      rst_n_i;
    redirect_t redirect_i;
    logic      stall_i;
    logic      inst_valid_o;
    inst_t     inst_o;
    pc_t       pc_o;

    integer seed;
    pc_t    model_pc;       // reference pc, tracks the DUT pc register
    logic   redirect_seen;
    logic   prev_valid;
    int     check_count;
    int     error_count;
    int     strobe_count;
    int     cycle_count;

    fetch_top UUT (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .redirect_i   (redirect_i),
        .stall_i      (stall_i),
        .inst_valid_o (inst_valid_o),
        .inst_o       (inst_o),
        .pc_o         (pc_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function pc_t rand_word64();
        rand_word64 = {$random(seed), $random(seed)};
    endfunction

    // priority: jump or taken branch, register jump, trap, then pc + 4
    function automatic pc_t model_next_pc(pc_t pc, redirect_t r, logic stall, logic adv);
        if (r.jal || (r.branch && r.cmp_zero)) begin
            return r.exec_pc + r.imm;
        end else if (r.jalr) begin
            return (r.rs1_data + r.imm) & ~64'h1;
        end else if (r.trap) begin
            return r.trap_vec;
        end else if (adv && !stall) begin
            return pc + 64'd4;
        end
        return pc;
    endfunction

    task automatic drive_inputs();
        redirect_t r;
        int        kind;
        r = '0;
        if (($random(seed) & 15) == 0) begin
            kind       = $unsigned($random(seed)) % 6;
            r.exec_pc  = rand_word64() & ~64'h1;  // keep jump targets even
            r.imm      = rand_word64() & ~64'h1;
            r.rs1_data = rand_word64();           // odd values hit the bit 0 clear
            r.trap_vec = rand_word64() & ~64'h3;
            case (kind)
                0: r.jal = 1'b1;
                1: begin
                    r.branch   = 1'b1;
                    r.cmp_zero = 1'b1;
                end
                2: r.branch = 1'b1;  // not taken, no redirect
                3: r.jalr = 1'b1;
                4: r.trap = 1'b1;
                default: begin
                    r.jal      = ($random(seed) & 1) != 0;
                    r.branch   = ($random(seed) & 1) != 0;
                    r.cmp_zero = ($random(seed) & 1) != 0;
                    r.jalr     = ($random(seed) & 1) != 0;
                    r.trap     = ($random(seed) & 1) != 0;
                end
            endcase
        end
        redirect_i = r;
        stall_i    = (($random(seed) & 7) == 0);
    endtask

    // runs just after each edge, inputs still hold what the edge used
    task automatic check_cycle();
        inst_t exp_inst;
        if (inst_valid_o === 1'b1) begin
            strobe_count++;
            check_count += 3;
            if (pc_o !== model_pc) begin
                error_count++;
                $display("Error at %0t: pc_o is %h, expected %h", $time, pc_o, model_pc);
            end
            exp_inst = model_pc[33:2] ^ MEM_PATTERN;
            if (inst_o !== exp_inst) begin
                error_count++;
                $display("Error at %0t: inst_o is %h, expected %h", $time, inst_o, exp_inst);
            end
            if (pc_o[0] !== 1'b0) begin
                error_count++;
                $display("Error at %0t: pc_o[0] is %b, expected 0", $time, pc_o[0]);
            end
            if (strobe_count == 1 && !redirect_seen) begin
                check_count++;
                if (pc_o !== RESET_PC) begin
                    error_count++;
                    $display("Error at %0t: first pc_o is %h, expected %h",
                             $time, pc_o, RESET_PC);
                end
            end
            if (prev_valid) begin
                error_count++;
                $display("inst_valid_o stayed high for two cycles at %0t", $time);
            end
        end
        if (redirect_i.jal || (redirect_i.branch && redirect_i.cmp_zero) ||
            redirect_i.jalr || redirect_i.trap) begin
            redirect_seen = 1'b1;
        end
        prev_valid = (inst_valid_o === 1'b1);
        model_pc   = model_next_pc(model_pc, redirect_i, stall_i, prev_valid);
    endtask

    initial begin
        seed          = 32'hdf6c8ee0;
        rst_n_i       = 1'b0;
        redirect_i    = '0;
        stall_i       = 1'b0;
        model_pc      = RESET_PC;
        redirect_seen = 1'b0;
        prev_valid    = 1'b0;
        check_count   = 0;
        error_count   = 0;
        strobe_count  = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        check_count++;
        if (inst_valid_o !== 1'b0) begin
            error_count++;
            $display("Error at %0t: inst_valid_o is %b, expected 0", $time, inst_valid_o);
        end
        #1;
        rst_n_i = 1'b1;
        repeat (STIM_CYCLES) begin
            @(posedge clk);
            #1;
            check_cycle();
            #1;
            drive_inputs();
        end
        check_count++;
        if (strobe_count < MIN_STROBES) begin
            error_count++;
            $display("only %0d strobes seen, the fetch loop looks stuck", strobe_count);
        end
        $display("checks %0d, strobes %0d, errors %0d", check_count, strobe_count, error_count);
        if (error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout after %0d cycles, the run did not finish", cycle_count);
        $display("Checks failed");
        $finish;
    end

endmodule

// ==== verilog.f ====
rtl/fetch_pkg.sv
rtl/mem_bus_pkg.sv
rtl/next_pc_sel.sv
rtl/fetch_ctrl.sv
rtl/inst_mem.sv
rtl/fetch_top.sv
test/tb_fetch_top.sv
